/* verilog/ti_mem_macros.svh */
`ifndef TI_MEM_MACROS_SVH
`define TI_MEM_MACROS_SVH

// --------------------
// Bus widths
// --------------------
`define TI_CPU_ADDR_W 19
`define TI_MEM_ADDR_W 25
`define TI_DATA_W     16
`define TI_ROMMASK_W  6

// --------------------
// Download indices
// --------------------
`define TI_IDX_C0 8'h01
`define TI_IDX_C1 8'h02
`define TI_IDX_D0 8'h03
`define TI_IDX_D1 8'h41
`define TI_IDX_G0 8'h04
`define TI_IDX_G1 8'h81

// Region offsets in the memory byte space
`define TI_OFS_D   25'h0002000
`define TI_OFS_G   25'h0086000
`define TI_OFS_ROM 25'h0080000

// Core enable period in clk_sys cycles
`define TI_CLK_EN_DIV 4

`endif

/* verilog/ti_mem_pkg.sv */
`include "ti_mem_macros.svh"

package ti_mem_pkg;

    // --------------------
    // Vector types
    // --------------------
    typedef logic [`TI_CPU_ADDR_W-1:0] cpu_addr_t;
    typedef logic [`TI_MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [`TI_DATA_W-1:0]     mem_data_t;
    typedef logic [7:0]                load_idx_t;
    // Active-high byte lanes, bit 1 is the upper byte
    typedef logic [1:0]                byte_sel_t;
    typedef logic [`TI_ROMMASK_W-1:0]  rom_mask_t;

    // --------------------
    // Bus structs
    // --------------------
    // RAM port of the console core, all strobes active low
    typedef struct packed {
        cpu_addr_t  addr;
        logic       ce_n;
        logic       we_n;
        logic [1:0] be_n;
        mem_data_t  wdata;
    } cpu_bus_t;

    // Image download stream
    typedef struct packed {
        logic       active;
        load_idx_t  index;
        mem_addr_t  addr;
        logic [7:0] data;
        logic       wr;
    } load_bus_t;

    // One memory access
    typedef struct packed {
        mem_addr_t addr;
        byte_sel_t sel;
        mem_data_t wdata;
        logic      we;
    } mem_cmd_t;

    typedef enum logic {
        IDLE,
        WAIT_ACK
    } ctrl_state_e;

endpackage

/* verilog/core_clk_gen.sv */
`timescale 1ns/100ps
`include "ti_mem_macros.svh"

module core_clk_gen (
    input  logic clk_sys,
    input  logic reset,
    input  logic load_active_i,
    output logic clk_en_o,
    output logic core_reset_o
);

    localparam int CNT_W = $clog2(`TI_CLK_EN_DIV);

    logic [CNT_W-1:0] en_cnt;

    // Core stays in reset while an image is coming in
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            core_reset_o <= 1'b1;
        end else begin
            core_reset_o <= load_active_i;
        end
    end

    // Divider restarts whenever the core is held in reset
    always_ff @(posedge clk_sys) begin
        if (reset || core_reset_o) begin
            en_cnt   <= '0;
            clk_en_o <= 1'b0;
        end else begin
            if (en_cnt == CNT_W'(`TI_CLK_EN_DIV - 1)) begin
                en_cnt <= '0;
            end else begin
                en_cnt <= en_cnt + 1'b1;
            end
            clk_en_o <= (en_cnt == CNT_W'(1));
        end
    end

    // Enable is a single-cycle strobe
    a_clk_en_single: assert property (@(posedge clk_sys) disable iff (reset)
        clk_en_o |=> !clk_en_o);

endmodule

/* verilog/rom_load_map.sv */
`timescale 1ns/100ps
`include "ti_mem_macros.svh"

module rom_load_map (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  ti_mem_pkg::load_bus_t load_i,
    output ti_mem_pkg::mem_cmd_t  load_cmd_o,
    output logic                  load_stb_o
);

    ti_mem_pkg::mem_addr_t region_ofs;
    ti_mem_pkg::byte_sel_t lane_sel;

    // --------------------
    // Region select
    // --------------------
    // C images sit at the bottom of the cartridge area
    always_comb begin
        case (load_i.index)
            `TI_IDX_C0, `TI_IDX_C1: begin
                region_ofs = '0;
            end
            `TI_IDX_D0, `TI_IDX_D1: begin
                region_ofs = `TI_OFS_D;
            end
            `TI_IDX_G0, `TI_IDX_G1: begin
                region_ofs = `TI_OFS_G;
            end
            default: begin
                region_ofs = `TI_OFS_ROM;
            end
        endcase
    end

    // Even byte address lands in the upper lane
    assign lane_sel = {~load_i.addr[0], load_i.addr[0]};

    // --------------------
    // Command register
    // --------------------
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            load_stb_o <= 1'b0;
        end else begin
            load_stb_o <= load_i.wr;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (load_i.wr) begin
            load_cmd_o.addr  <= load_i.addr + region_ofs;
            load_cmd_o.sel   <= lane_sel;
            // Byte goes out on both halves, the lane picks one
            load_cmd_o.wdata <= {load_i.data, load_i.data};
            load_cmd_o.we    <= 1'b1;
        end
    end

    // A new write may not land before the previous one has been handed off
    a_load_spacing: assert property (@(posedge clk_sys) disable iff (reset)
        load_i.wr |=> !load_i.wr);

endmodule

/* verilog/rom_mask_track.sv */
`timescale 1ns/100ps
`include "ti_mem_macros.svh"

module rom_mask_track (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  ti_mem_pkg::load_bus_t load_i,
    output ti_mem_pkg::rom_mask_t rommask_o
);

    ti_mem_pkg::load_idx_t last_idx;
    ti_mem_pkg::mem_addr_t last_addr;
    logic                  last_is_d;

    // Last download write seen
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            last_idx  <= '0;
            last_addr <= '0;
        end else if (load_i.wr) begin
            last_idx  <= load_i.index;
            last_addr <= load_i.addr;
        end
    end

    assign last_is_d = (last_idx == `TI_IDX_D0) || (last_idx == `TI_IDX_D1);

    // --------------------
    // Page mask from D image size
    // --------------------
    always_comb begin
        if (!last_is_d) begin
            rommask_o = '1;
        end else if (last_addr < 25'h0004000) begin
            rommask_o = 6'b000001;
        end else if (last_addr < 25'h0008000) begin
            rommask_o = 6'b000011;
        end else if (last_addr < 25'h0010000) begin
            rommask_o = 6'b000111;
        end else if (last_addr < 25'h0020000) begin
            rommask_o = 6'b001111;
        end else if (last_addr < 25'h0040000) begin
            rommask_o = 6'b011111;
        end else begin
            rommask_o = 6'b111111;
        end
    end

endmodule

/* verilog/ti_mem_ctrl.sv */
`timescale 1ns/100ps

module ti_mem_ctrl (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  ti_mem_pkg::cpu_bus_t  cpu_i,
    input  logic                  load_active_i,
    input  logic                  load_stb_i,
    input  ti_mem_pkg::mem_cmd_t  load_cmd_i,
    output ti_mem_pkg::mem_cmd_t  mem_cmd_o,
    output logic                  mem_req_o,
    input  logic                  mem_ack_i,
    input  ti_mem_pkg::mem_data_t mem_q_i,
    output ti_mem_pkg::mem_data_t cpu_q_o,
    output logic                  cpu_ack_o
);

    ti_mem_pkg::ctrl_state_e state;
    ti_mem_pkg::mem_cmd_t    cpu_cmd;
    logic                    cpu_rd;
    logic                    cpu_wr;
    logic                    cpu_rd_q;
    logic                    cpu_wr_q;
    logic                    cpu_start;
    logic                    cur_is_cpu;

    // --------------------
    // CPU access detect
    // --------------------
    assign cpu_rd = ~cpu_i.ce_n & cpu_i.we_n;
    assign cpu_wr = ~cpu_i.ce_n & ~cpu_i.we_n;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            cpu_rd_q <= 1'b0;
            cpu_wr_q <= 1'b0;
        end else begin
            cpu_rd_q <= cpu_rd;
            cpu_wr_q <= cpu_wr;
        end
    end

    // Core is held in reset during a download, its strobes are meaningless
    assign cpu_start = ((cpu_rd & ~cpu_rd_q) | (cpu_wr & ~cpu_wr_q)) & ~load_active_i;

    // Word address to byte address
    assign cpu_cmd.addr  = ti_mem_pkg::mem_addr_t'({cpu_i.addr, 1'b0});
    assign cpu_cmd.sel   = ~cpu_i.be_n;
    assign cpu_cmd.wdata = cpu_i.wdata;
    assign cpu_cmd.we    = ~cpu_i.we_n;

    // --------------------
    // Toggle handshake FSM
    // --------------------
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state      <= ti_mem_pkg::IDLE;
            mem_req_o  <= 1'b0;
            cur_is_cpu <= 1'b0;
            cpu_ack_o  <= 1'b0;
        end else begin
            cpu_ack_o <= 1'b0;
            case (state)
                ti_mem_pkg::IDLE: begin
                    if (load_stb_i) begin
                        mem_req_o  <= ~mem_req_o;
                        cur_is_cpu <= 1'b0;
                        state      <= ti_mem_pkg::WAIT_ACK;
                    end else if (cpu_start) begin
                        mem_req_o  <= ~mem_req_o;
                        cur_is_cpu <= 1'b1;
                        state      <= ti_mem_pkg::WAIT_ACK;
                    end
                end
                ti_mem_pkg::WAIT_ACK: begin
                    // Memory answers by matching the request level
                    if (mem_ack_i == mem_req_o) begin
                        cpu_ack_o <= cur_is_cpu;
                        state     <= ti_mem_pkg::IDLE;
                    end
                end
                default: begin
                    state <= ti_mem_pkg::IDLE;
                end
            endcase
        end
    end

    // Command and read data registers
    always_ff @(posedge clk_sys) begin
        if (state == ti_mem_pkg::IDLE) begin
            if (load_stb_i) begin
                mem_cmd_o <= load_cmd_i;
            end else if (cpu_start) begin
                mem_cmd_o <= cpu_cmd;
            end
        end
        if (state == ti_mem_pkg::WAIT_ACK && mem_ack_i == mem_req_o &&
            cur_is_cpu && !mem_cmd_o.we) begin
            cpu_q_o <= mem_q_i;
        end
    end

    // --------------------
    // Checks
    // --------------------
    // Sources must wait for the previous access to finish
    a_no_start_busy: assert property (@(posedge clk_sys) disable iff (reset)
        (state == ti_mem_pkg::WAIT_ACK) |-> !(load_stb_i || cpu_start));

    a_cmd_stable: assert property (@(posedge clk_sys) disable iff (reset)
        (mem_req_o != mem_ack_i) |=> $stable(mem_cmd_o));

endmodule

/* verilog/ti_mem_top.sv */
`timescale 1ns/100ps

module ti_mem_top (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  ti_mem_pkg::cpu_bus_t  cpu_i,
    input  ti_mem_pkg::load_bus_t load_i,
    output ti_mem_pkg::mem_cmd_t  mem_cmd_o,
    output logic                  mem_req_o,
    input  logic                  mem_ack_i,
    input  ti_mem_pkg::mem_data_t mem_q_i,
    output ti_mem_pkg::mem_data_t cpu_q_o,
    output logic                  cpu_ack_o,
    output ti_mem_pkg::rom_mask_t rommask_o,
    output logic                  clk_en_o,
    output logic                  core_reset_o
);

    ti_mem_pkg::mem_cmd_t load_cmd;
    logic                 load_stb;

    // --------------------
    // Core timing
    // --------------------
    core_clk_gen u_core_clk_gen (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .load_active_i (load_i.active),
        .clk_en_o      (clk_en_o),
        .core_reset_o  (core_reset_o)
    );

    // --------------------
    // Download path
    // --------------------
    rom_load_map u_rom_load_map (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .load_i     (load_i),
        .load_cmd_o (load_cmd),
        .load_stb_o (load_stb)
    );

    rom_mask_track u_rom_mask_track (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .load_i    (load_i),
        .rommask_o (rommask_o)
    );

    // Shared memory port
    ti_mem_ctrl u_ti_mem_ctrl (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .cpu_i         (cpu_i),
        .load_active_i (load_i.active),
        .load_stb_i    (load_stb),
        .load_cmd_i    (load_cmd),
        .mem_cmd_o     (mem_cmd_o),
        .mem_req_o     (mem_req_o),
        .mem_ack_i     (mem_ack_i),
        .mem_q_i       (mem_q_i),
        .cpu_q_o       (cpu_q_o),
        .cpu_ack_o     (cpu_ack_o)
    );

endmodule

/* dv/tb_ti_mem_top.sv */
`timescale 1ns/100ps
`include "ti_mem_macros.svh"

module tb_ti_mem_top;

    localparam int MAX_CYCLES = 4000;
    localparam int N_CPU      = 12;

    logic                  clk_sys = 1'b0;
    logic                  reset;
    ti_mem_pkg::cpu_bus_t  cpu;
    ti_mem_pkg::load_bus_t load;
    ti_mem_pkg::mem_cmd_t  mem_cmd;
    logic                  mem_req;
    logic                  mem_ack;
    ti_mem_pkg::mem_data_t mem_q;
    ti_mem_pkg::mem_data_t cpu_q;
    logic                  cpu_ack;
    ti_mem_pkg::rom_mask_t rommask;
    logic                  clk_en;
    logic                  core_reset;

    ti_mem_pkg::mem_cmd_t  exp_cmd_q[$];
    ti_mem_pkg::mem_cmd_t  exp_cmd;
    ti_mem_pkg::mem_data_t exp_rd;
    logic [7:0]            mem_b[ti_mem_pkg::mem_addr_t];
    logic [7:0]            shadow_b[ti_mem_pkg::mem_addr_t];
    logic [31:0]           lfsr = 32'h79c;
    logic                  req_d;
    logic                  cmd_chk;
    logic                  rd_chk;
    logic                  dl_phase;
    int                    assert_errs;
    int                    other_errs;
    int                    cycles;
    int                    ack_cnt;
    int                    cpu_cnt;

    ti_mem_top u_dut (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .cpu_i        (cpu),
        .load_i       (load),
        .mem_cmd_o    (mem_cmd),
        .mem_req_o    (mem_req),
        .mem_ack_i    (mem_ack),
        .mem_q_i      (mem_q),
        .cpu_q_o      (cpu_q),
        .cpu_ack_o    (cpu_ack),
        .rommask_o    (rommask),
        .clk_en_o     (clk_en),
        .core_reset_o (core_reset)
    );

    always #2 clk_sys = ~clk_sys;

    // --------------------
    // Helpers
    // --------------------
    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [7:0] fill_byte(input ti_mem_pkg::mem_addr_t a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'b0, a[24]};
    endfunction

    function automatic ti_mem_pkg::mem_cmd_t load_exp(input logic [7:0] idx,
            input ti_mem_pkg::mem_addr_t a, input logic [7:0] d);
        ti_mem_pkg::mem_cmd_t c;
        if (idx == 8'h01 || idx == 8'h02) c.addr = a;
        else if (idx == 8'h03 || idx == 8'h41) c.addr = a + 25'h2000;
        else if (idx == 8'h04 || idx == 8'h81) c.addr = a + 25'h86000;
        else c.addr = a + 25'h80000;
        c.sel   = a[0] ? 2'b01 : 2'b10;
        c.wdata = {d, d};
        c.we    = 1'b1;
        return c;
    endfunction

    function automatic ti_mem_pkg::rom_mask_t mask_for(input logic [7:0] idx,
            input ti_mem_pkg::mem_addr_t a);
        if (idx != 8'h03 && idx != 8'h41) return 6'b111111;
        if (a < 25'h4000) return 6'b000001;
        if (a < 25'h8000) return 6'b000011;
        if (a < 25'h10000) return 6'b000111;
        if (a < 25'h20000) return 6'b001111;
        if (a < 25'h40000) return 6'b011111;
        return 6'b111111;
    endfunction

    // --------------------
    // Memory model
    // --------------------
    always begin
        ti_mem_pkg::mem_addr_t base;
        int                    dly;
        @(posedge clk_sys);
        if (!reset && mem_req != mem_ack) begin
            dly = 1 + int'(rand_bits(3));
            repeat (dly - 1) @(posedge clk_sys);
            base = {mem_cmd.addr[24:1], 1'b0};
            if (mem_cmd.we) begin
                if (mem_cmd.sel[1]) mem_b[base] = mem_cmd.wdata[15:8];
                if (mem_cmd.sel[0]) mem_b[base | 25'h1] = mem_cmd.wdata[7:0];
            end
            mem_q   <= {mem_b.exists(base) ? mem_b[base] : fill_byte(base),
                        mem_b.exists(base | 25'h1) ? mem_b[base | 25'h1]
                                                   : fill_byte(base | 25'h1)};
            mem_ack <= mem_req;
        end
    end

    // Each request toggle takes the next expected command
    always @(posedge clk_sys) begin
        cycles  <= cycles + 1;
        req_d   <= reset ? 1'b0 : mem_req;
        cmd_chk <= 1'b0;
        if (cpu_ack) ack_cnt <= ack_cnt + 1;
        if (!reset && mem_req != req_d) begin
            if (exp_cmd_q.size() == 0) begin
                other_errs <= other_errs + 1;
                $display("Memory request at %0t with no access expected", $time);
            end else begin
                exp_cmd <= exp_cmd_q.pop_front();
                cmd_chk <= 1'b1;
            end
        end
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // --------------------
    // Checks
    // --------------------
    a_reset_state: assert property (@(posedge clk_sys) $fell(reset) |->
        (!cpu_ack && !clk_en && !mem_req && rommask == '1 && core_reset))
        else begin
            assert_errs++;
            $display({"ERROR %0t {cpu_ack_o,clk_en_o,mem_req_o,rommask_o,core_reset_o}",
                " got %b expected %b"}, $time,
                {$sampled(cpu_ack), $sampled(clk_en), $sampled(mem_req),
                 $sampled(rommask), $sampled(core_reset)}, 10'b0001111111);
        end

    a_cmd: assert property (@(posedge clk_sys) cmd_chk |-> mem_cmd == exp_cmd)
        else begin
            assert_errs++;
            $display("ERROR %0t mem_cmd_o got %h expected %h", $time, mem_cmd, exp_cmd);
        end

    a_rd: assert property (@(posedge clk_sys) (cpu_ack && rd_chk) |-> cpu_q == exp_rd)
        else begin
            assert_errs++;
            $display("ERROR %0t cpu_q_o got %h expected %h", $time, cpu_q, exp_rd);
        end

    a_mask: assert property (@(posedge clk_sys) disable iff (reset)
        load.wr |=> rommask == mask_for($past(load.index), $past(load.addr)))
        else begin
            assert_errs++;
            $display("ERROR %0t rommask_o got %b expected %b", $time, rommask,
                mask_for($past(load.index), $past(load.addr)));
        end

    a_no_dl_ack: assert property (@(posedge clk_sys) dl_phase |-> !cpu_ack)
        else begin
            assert_errs++;
            $display("ERROR %0t cpu_ack_o got %b expected 0", $time, $sampled(cpu_ack));
        end

    a_ack_single: assert property (@(posedge clk_sys) disable iff (reset) cpu_ack |=> !cpu_ack)
        else begin
            assert_errs++;
            $display("cpu_ack_o held longer than one cycle at %0t", $time);
        end

    a_en_first: assert property (@(posedge clk_sys) disable iff (reset)
        $fell(core_reset) |-> !clk_en ##1 !clk_en ##1 clk_en)
        else begin
            assert_errs++;
            $display("First clock enable not 2 cycles after core reset at %0t", $time);
        end

    a_en_period: assert property (@(posedge clk_sys) disable iff (reset)
        clk_en ##1 (!core_reset)[*3] |=> clk_en)
        else begin
            assert_errs++;
            $display("Clock enable period not 4 cycles at %0t", $time);
        end

    a_en_gap: assert property (@(posedge clk_sys) disable iff (reset) clk_en |=> !clk_en[*3])
        else begin
            assert_errs++;
            $display("Clock enable pulses too close at %0t", $time);
        end

    a_core_rst: assert property (@(posedge clk_sys) disable iff (reset)
        $rose(load.active) |=> core_reset)
        else begin
            assert_errs++;
            $display("ERROR %0t core_reset_o got %b expected 1", $time,
                $sampled(core_reset));
        end

    // --------------------
    // Stimulus
    // --------------------
    task automatic load_write(input logic [7:0] idx, input ti_mem_pkg::mem_addr_t a);
        logic [7:0]           d;
        ti_mem_pkg::mem_cmd_t c;
        d = 8'(rand_bits(8));
        c = load_exp(idx, a, d);
        exp_cmd_q.push_back(c);
        // Downloaded byte is visible to later CPU reads
        shadow_b[c.addr] = d;
        load.index <= idx;
        load.addr  <= a;
        load.data  <= d;
        load.wr    <= 1'b1;
        @(posedge clk_sys);
        load.wr <= 1'b0;
        repeat (23) @(posedge clk_sys);
    endtask

    task automatic cpu_access(input ti_mem_pkg::cpu_addr_t a, input logic wr,
            input logic [1:0] be_n, input ti_mem_pkg::mem_data_t d);
        ti_mem_pkg::mem_addr_t base;
        base = ti_mem_pkg::mem_addr_t'({a, 1'b0});
        exp_cmd_q.push_back('{addr: base, sel: ~be_n, wdata: d, we: wr});
        if (wr) begin
            if (!be_n[1]) shadow_b[base] = d[15:8];
            if (!be_n[0]) shadow_b[base | 25'h1] = d[7:0];
        end else begin
            exp_rd <= {shadow_b.exists(base) ? shadow_b[base] : fill_byte(base),
                       shadow_b.exists(base | 25'h1) ? shadow_b[base | 25'h1]
                                                     : fill_byte(base | 25'h1)};
            rd_chk <= 1'b1;
        end
        cpu_cnt++;
        cpu       <= '{addr: a, ce_n: 1'b0, we_n: !wr, be_n: be_n, wdata: d};
        @(posedge clk_sys);
        while (!cpu_ack) @(posedge clk_sys);
        rd_chk    <= 1'b0;
        cpu.ce_n  <= 1'b1;
        cpu.we_n  <= 1'b1;
        repeat (2) @(posedge clk_sys);
    endtask

    initial begin
        ti_mem_pkg::cpu_addr_t addrs[N_CPU];
        logic [1:0]            be_r;
        reset = 1'b1;
        cpu = '{addr: '0, ce_n: 1'b1, we_n: 1'b1, be_n: 2'b11, wdata: '0};
        load = '0;
        mem_ack = 1'b0;
        mem_q = '0;
        exp_cmd = '0;
        exp_rd = '0;
        rd_chk = 1'b0;
        dl_phase = 1'b0;
        assert_errs = 0;
        other_errs = 0;
        cycles = 0;
        ack_cnt = 0;
        cpu_cnt = 0;
        repeat (4) @(posedge clk_sys);
        reset <= 1'b0;
        repeat (20) @(posedge clk_sys);

        // Downloads of every index class and each mask band
        load.active <= 1'b1;
        dl_phase    <= 1'b1;
        load_write(`TI_IDX_C0, 25'h0000010);
        load_write(`TI_IDX_C1, 25'h0000011);
        load_write(`TI_IDX_G0, 25'h0000100);
        // CPU strobe while the download holds the core
        cpu.ce_n <= 1'b0;
        repeat (2) @(posedge clk_sys);
        cpu.ce_n <= 1'b1;
        repeat (2) @(posedge clk_sys);
        load_write(`TI_IDX_G1, 25'h0000201);
        load_write(8'h10, 25'h0000302);
        load_write(`TI_IDX_D0, 25'h0003fff);
        load_write(`TI_IDX_D1, 25'h0007fff);
        load_write(`TI_IDX_D0, 25'h000fffe);
        load_write(`TI_IDX_D1, 25'h001ffff);
        load_write(`TI_IDX_D0, 25'h003fffe);
        load_write(`TI_IDX_D1, 25'h0040000);
        load_write(`TI_IDX_C0, 25'h0000020);
        load.active <= 1'b0;
        dl_phase    <= 1'b0;
        repeat (12) @(posedge clk_sys);

        // CPU writes, then reads of the same words
        for (int i = 0; i < N_CPU; i++) begin
            addrs[i] = ti_mem_pkg::cpu_addr_t'(rand_bits(19));
            be_r     = 2'(rand_bits(2));
            cpu_access(addrs[i], 1'b1, be_r, ti_mem_pkg::mem_data_t'(rand_bits(16)));
        end
        for (int i = 0; i < N_CPU; i++) begin
            be_r = 2'(rand_bits(2));
            cpu_access(addrs[i], 1'b0, be_r, '0);
        end
        repeat (20) @(posedge clk_sys);

        if (exp_cmd_q.size() != 0) begin
            other_errs++;
            $display("%0d expected memory requests never issued", exp_cmd_q.size());
        end
        if (ack_cnt != cpu_cnt) begin
            other_errs++;
            $display("ERROR %0t cpu_ack_o count got %0d expected %0d", $time, ack_cnt, cpu_cnt);
        end
        $display("Errors: %0d assertion, %0d other", assert_errs, other_errs);
        if (assert_errs == 0 && other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+verilog
verilog/ti_mem_pkg.sv
verilog/core_clk_gen.sv
verilog/rom_load_map.sv
verilog/rom_mask_track.sv
verilog/ti_mem_ctrl.sv
verilog/ti_mem_top.sv
dv/tb_ti_mem_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ti_mem_top
LOG       ?= sim.log
BUILD     ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --assert --timing -f verilog.f --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
